// File: Bender.yml
package:
  name: fe_top

sources:
  - common/fe_pkg.sv
  - pc_gen/fe_pc_gen.sv
  - src/fe_imem.sv
  - src/fe_region_check.sv
  - src/fe_queue_former.sv
  - src/fe_top.sv
  - target: test
    files:
      - bench/fe_top_tb.sv

// File: bench/fe_testdata.txt
# Records: W index data | R pc | H | E msg pc instr | Q cycles | T name
# msg is 0 instr, 1 access fault, 2 misaligned; msg and Q are decimal, the rest hex
T in_order
W 00 00000013
W 01 00100093
W 02 00200113
W 03 00308193
W 04 00418213
W 05 00520293
R 00001000
E 0 00001000 00000013
E 0 00001004 00100093
E 0 00001008 00200113
E 0 0000100c 00308193
E 0 00001010 00418213
E 0 00001014 00520293
T misaligned
R 00001002
E 2 00001002 00000000
Q 20
T past_limit
W fe 0fe00613
W ff 0000006f
R 000013f8
E 0 000013f8 0fe00613
E 0 000013fc 0000006f
E 1 00001400 00000000
Q 20
T halt
R 00001000
E 0 00001000 00000013
E 0 00001004 00100093
H
Q 10
W 02 deadbeef
T rewrite
R 00001008
E 0 00001008 deadbeef
E 0 0000100c 00308193
T mid_redirect
R 00001004
E 0 00001004 00100093
E 0 00001008 deadbeef
E 0 0000100c 00308193

// File: bench/fe_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fe_top_tb
  import fe_pkg::*;
();

  localparam int timeout_cycles = 200;

  logic       clk;
  logic       reset;
  logic       fe_cmd_v;
  fe_cmd_op_e fe_cmd_op;
  vaddr_t     fe_cmd_pc;
  logic       fe_cmd_yumi;
  logic       imem_w_v;
  imem_addr_t imem_w_addr;
  instr_t     imem_w_data;
  logic       fe_queue_v;
  fe_msg_e    fe_queue_msg;
  vaddr_t     fe_queue_pc;
  instr_t     fe_queue_instr;
  logic       fe_queue_ready;

  logic [31:0] rng_state;
  logic        stream_open;
  logic        msg_seen;
  logic        yumi_seen;
  fe_msg_e     got_msg;
  vaddr_t      got_pc;
  instr_t      got_instr;
  string       test_name;

  fe_top DUT (
    .clk_i            (clk),
    .reset_i          (reset),
    .fe_cmd_v_i       (fe_cmd_v),
    .fe_cmd_op_i      (fe_cmd_op),
    .fe_cmd_pc_i      (fe_cmd_pc),
    .fe_cmd_yumi_o    (fe_cmd_yumi),
    .imem_w_v_i       (imem_w_v),
    .imem_w_addr_i    (imem_w_addr),
    .imem_w_data_i    (imem_w_data),
    .fe_queue_v_o     (fe_queue_v),
    .fe_queue_msg_o   (fe_queue_msg),
    .fe_queue_pc_o    (fe_queue_pc),
    .fe_queue_instr_o (fe_queue_instr),
    .fe_queue_ready_i (fe_queue_ready)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic abort_run();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic fail_plain(input string what);
    $display("%s: %s", test_name, what);
    abort_run();
  endtask

  task automatic check_msg(input string name, input fe_msg_e expected, input fe_msg_e actual);
    if (actual !== expected)
    begin
      $display("Mismatch %s msg: expected %0d, actual %0d", name, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_pc(input string name, input vaddr_t expected, input vaddr_t actual);
    if (actual !== expected)
    begin
      $display("Mismatch %s pc: expected %h, actual %h", name, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_instr(input string name, input instr_t expected, input instr_t actual);
    if (actual !== expected)
    begin
      $display("Mismatch %s instr: expected %h, actual %h", name, expected, actual);
      abort_run();
    end
  endtask

  // New inputs on each falling edge with ready high about 70 percent of the time
  task automatic begin_cycle();
    @(negedge clk);
    fe_cmd_v       = 1'b0;
    imem_w_v       = 1'b0;
    rng_state      = lcg_step(rng_state);
    fe_queue_ready = (rng_state[30:16] % 100) < 70;
  endtask

  // Sample a quarter period before the rising edge
  task automatic end_cycle();
    #2;
    if ($isunknown({fe_queue_v, fe_cmd_yumi}))
      fail_plain("a handshake output is unknown");
    // Commands are taken in the cycle they are offered
    if (fe_cmd_yumi !== fe_cmd_v)
      fail_plain("the command yumi does not follow the command valid");
    msg_seen  = fe_queue_v;
    yumi_seen = fe_cmd_yumi;
    got_msg   = fe_queue_msg;
    got_pc    = fe_queue_pc;
    got_instr = fe_queue_instr;
    if (msg_seen && !fe_queue_ready)
      fail_plain("a message was offered while the queue was not ready");
  endtask

  task automatic watch_stream();
    if (msg_seen && !stream_open)
      fail_plain($sformatf("unexpected message at pc %h", got_pc));
  endtask

  task automatic load_word(input imem_addr_t idx, input instr_t data);
    begin_cycle();
    imem_w_v    = 1'b1;
    imem_w_addr = idx;
    imem_w_data = data;
    end_cycle();
    watch_stream();
  endtask

  task automatic send_command(input fe_cmd_op_e op, input vaddr_t pc);
    int waited;
    waited    = 0;
    yumi_seen = 1'b0;
    while (!yumi_seen)
    begin
      if (waited == timeout_cycles)
        fail_plain("the command was never accepted");
      begin_cycle();
      fe_cmd_v  = 1'b1;
      fe_cmd_op = op;
      fe_cmd_pc = pc;
      end_cycle();
      watch_stream();
      waited++;
    end
    // The stage is flushed in the accepting cycle
    if (msg_seen)
      fail_plain("a message appeared in the cycle a command was accepted");
    stream_open = 1'b0;
  endtask

  task automatic expect_message(input fe_msg_e exp_msg, input vaddr_t exp_pc,
                                input instr_t exp_instr);
    int waited;
    waited   = 0;
    msg_seen = 1'b0;
    while (!msg_seen)
    begin
      if (waited == timeout_cycles)
        fail_plain($sformatf("no message arrived for pc %h", exp_pc));
      begin_cycle();
      end_cycle();
      waited++;
    end
    check_msg(test_name, exp_msg, got_msg);
    check_pc(test_name, exp_pc, got_pc);
    check_instr(test_name, exp_instr, got_instr);
    stream_open = 1'b1;
  endtask

  task automatic expect_silence(input int cycles);
    repeat (cycles)
    begin
      begin_cycle();
      end_cycle();
      if (msg_seen)
        fail_plain($sformatf("message at pc %h during expected silence", got_pc));
    end
  endtask

  initial
  begin
    int          fd;
    int          code;
    string       tag;
    string       rest;
    logic [31:0] arg_a;
    logic [31:0] arg_b;
    logic [31:0] arg_c;
    clk            = 1'b0;
    reset          = 1'b1;
    fe_cmd_v       = 1'b0;
    fe_cmd_op      = e_op_redirect;
    fe_cmd_pc      = '0;
    imem_w_v       = 1'b0;
    imem_w_addr    = '0;
    imem_w_data    = '0;
    fe_queue_ready = 1'b0;
    rng_state      = 32'd93085;
    stream_open    = 1'b0;
    msg_seen       = 1'b0;
    yumi_seen      = 1'b0;
    test_name      = "reset";
    repeat (10) @(negedge clk);
    reset = 1'b0;

    fd = $fopen("bench/fe_testdata.txt", "r");
    if (fd == 0)
      fail_plain("cannot open bench/fe_testdata.txt");
    while ($fscanf(fd, "%s", tag) == 1)
    begin
      if (tag.substr(0, 0) == "#")
        code = $fgets(rest, fd);
      else if (tag == "T")
        code = $fscanf(fd, "%s", test_name);
      else if (tag == "W")
      begin
        if ($fscanf(fd, "%h %h", arg_a, arg_b) != 2)
          fail_plain("malformed W record");
        load_word(arg_a[imem_addr_width-1:0], arg_b);
      end
      else if (tag == "R")
      begin
        if ($fscanf(fd, "%h", arg_a) != 1)
          fail_plain("malformed R record");
        send_command(e_op_redirect, arg_a);
      end
      else if (tag == "H")
        send_command(e_op_halt, '0);
      else if (tag == "E")
      begin
        if ($fscanf(fd, "%d %h %h", arg_a, arg_b, arg_c) != 3)
          fail_plain("malformed E record");
        expect_message(fe_msg_e'(arg_a[1:0]), arg_b, arg_c);
      end
      else if (tag == "Q")
      begin
        if ($fscanf(fd, "%d", arg_a) != 1)
          fail_plain("malformed Q record");
        expect_silence(arg_a);
      end
      else
        fail_plain($sformatf("unknown record %s in the stimulus file", tag));
    end
    $fclose(fd);
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: common/fe_pkg.sv
`default_nettype none

package fe_pkg;

  // Datapath widths
  localparam int vaddr_width     = 32;
  localparam int instr_width     = 32;
  localparam int imem_words      = 256;
  localparam int imem_addr_width = 8;

  typedef logic [vaddr_width-1:0]     vaddr_t;
  typedef logic [instr_width-1:0]     instr_t;
  typedef logic [imem_addr_width-1:0] imem_addr_t;

  // Executable region, sized to cover the instruction memory exactly
  localparam vaddr_t exec_base  = 32'h0000_1000;
  localparam vaddr_t exec_limit = exec_base + vaddr_t'(imem_words * (instr_width / 8));

  // Commands from the backend
  typedef enum logic
  {
    e_op_redirect = 1'b0,
    e_op_halt     = 1'b1
  } fe_cmd_op_e;

  // Fetch queue message types
  typedef enum logic [1:0]
  {
    e_msg_instr        = 2'd0,
    e_msg_access_fault = 2'd1,
    e_msg_misaligned   = 2'd2
  } fe_msg_e;

endpackage

`default_nettype wire

// File: fe_top.f
common/fe_pkg.sv
pc_gen/fe_pc_gen.sv
src/fe_imem.sv
src/fe_region_check.sv
src/fe_queue_former.sv
src/fe_top.sv
bench/fe_top_tb.sv

// File: pc_gen/fe_pc_gen.sv
`timescale 1ns/1ps
`default_nettype none

module fe_pc_gen
  import fe_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,

  input  logic       fe_cmd_v_i,
  input  fe_cmd_op_e fe_cmd_op_i,
  input  vaddr_t     fe_cmd_pc_i,
  output logic       fe_cmd_yumi_o,

  input  logic       fail_v_i,
  input  vaddr_t     fail_pc_i,
  input  logic       fault_sent_i,
  input  logic       resume_ready_i,

  output logic       fetch_v_o,
  output vaddr_t     fetch_pc_o,
  output logic       flush_o
);

  typedef enum logic [1:0]
  {
    e_wait  = 2'd0,
    e_run   = 2'd1,
    e_stall = 2'd2
  } state_e;

  state_e state_r;
  state_e state_n;

  logic   redirect_v;
  logic   halt_v;
  logic   cmd_accept;
  logic   stall_exit;
  logic   resume_sel_r;
  vaddr_t resume_pc_r;
  vaddr_t next_pc_r;

  assign redirect_v = fe_cmd_v_i & (fe_cmd_op_i == e_op_redirect);
  assign halt_v     = fe_cmd_v_i & (fe_cmd_op_i == e_op_halt);
  assign cmd_accept = redirect_v | halt_v;

  // Every command is taken on arrival
  assign fe_cmd_yumi_o = cmd_accept;
  assign flush_o       = cmd_accept;

  assign stall_exit = (state_r == e_stall) & resume_ready_i & ~cmd_accept;

  always_comb
  begin
    state_n = state_r;
    if (redirect_v)
      state_n = e_run;
    else if (halt_v)
      state_n = e_wait;
    else
    begin
      case (state_r)
        e_run:
          if (fail_v_i)
            state_n = e_stall;
          else if (fault_sent_i)
            state_n = e_wait;
        e_stall:
          if (resume_ready_i)
            state_n = e_run;
        default:
          state_n = e_wait;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r      <= e_wait;
      resume_sel_r <= 1'b0;
    end
    else
    begin
      state_r      <= state_n;
      // First issue after entering run comes from the resume PC
      resume_sel_r <= redirect_v | stall_exit;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (redirect_v)
      resume_pc_r <= fe_cmd_pc_i;
    else if (fail_v_i)
      resume_pc_r <= fail_pc_i;
    if (fetch_v_o)
      next_pc_r <= fetch_pc_o + vaddr_t'(4);
  end

  assign fetch_v_o  = (state_r == e_run);
  assign fetch_pc_o = resume_sel_r ? resume_pc_r : next_pc_r;

  assert property (@(posedge clk_i) disable iff (reset_i)
    (state_r inside {e_wait, e_stall}) |-> !fetch_v_o);

  assert property (@(posedge clk_i) disable iff (reset_i)
    fe_cmd_yumi_o |-> fe_cmd_v_i);

  // A failed item leaves a cycle of silence while the replay is set up
  assert property (@(posedge clk_i) disable iff (reset_i)
    fail_v_i |=> !fetch_v_o);

endmodule

`default_nettype wire

// File: src/fe_imem.sv
`timescale 1ns/1ps
`default_nettype none

module fe_imem
  import fe_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,

  input  logic       imem_w_v_i,
  input  imem_addr_t imem_w_addr_i,
  input  instr_t     imem_w_data_i,

  input  logic       rd_v_i,
  input  vaddr_t     rd_pc_i,
  output instr_t     rd_instr_o
);

  instr_t     mem [0:imem_words-1];
  vaddr_t     rd_offset;
  imem_addr_t rd_idx;

  // Word index relative to the start of the executable region
  assign rd_offset = rd_pc_i - exec_base;
  assign rd_idx    = rd_offset[imem_addr_width+1:2];

  // Same-index write and read returns the old word
  always_ff @(posedge clk_i)
  begin
    if (imem_w_v_i)
      mem[imem_w_addr_i] <= imem_w_data_i;
    if (rd_v_i)
      rd_instr_o <= mem[rd_idx];
  end

  assert property (@(posedge clk_i) disable iff (reset_i)
    imem_w_v_i |-> !$isunknown(imem_w_addr_i));

endmodule

`default_nettype wire

// File: src/fe_queue_former.sv
`timescale 1ns/1ps
`default_nettype none

module fe_queue_former
  import fe_pkg::*;
(
  input  logic    clk_i,
  input  logic    reset_i,

  input  logic    fetch_v_i,
  input  vaddr_t  fetch_pc_i,
  input  logic    flush_i,

  input  instr_t  rd_instr_i,
  input  logic    access_fault_i,
  input  logic    misaligned_i,

  input  logic    fe_queue_ready_i,
  output logic    fe_queue_v_o,
  output fe_msg_e fe_queue_msg_o,
  output vaddr_t  fe_queue_pc_o,
  output instr_t  fe_queue_instr_o,

  output logic    fail_v_o,
  output vaddr_t  fail_pc_o,
  output logic    fault_sent_o,
  output logic    resume_ready_o
);

  logic    stage_v_r;
  logic    stage_squash_r;
  vaddr_t  stage_pc_r;
  logic    stage_live;
  logic    fault_v;
  fe_msg_e msg_type;

  // Item issued last cycle, still alive unless squashed or flushed now
  assign stage_live = stage_v_r & ~stage_squash_r & ~flush_i;
  assign fault_v    = misaligned_i | access_fault_i;

  always_comb
  begin
    if (misaligned_i)
      msg_type = e_msg_misaligned;
    else if (access_fault_i)
      msg_type = e_msg_access_fault;
    else
      msg_type = e_msg_instr;
  end

  assign fe_queue_v_o     = stage_live & fe_queue_ready_i;
  assign fe_queue_msg_o   = msg_type;
  assign fe_queue_pc_o    = stage_pc_r;
  assign fe_queue_instr_o = fault_v ? '0 : rd_instr_i;

  // No buffering: a blocked item is dropped and replayed from its PC
  assign fail_v_o       = stage_live & ~fe_queue_ready_i;
  assign fail_pc_o      = stage_pc_r;
  assign fault_sent_o   = fe_queue_v_o & fault_v;
  assign resume_ready_o = fe_queue_ready_i;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      stage_v_r      <= 1'b0;
      stage_squash_r <= 1'b0;
    end
    else
    begin
      stage_v_r      <= fetch_v_i;
      // Younger item issued alongside a flush, fail or fault is dead
      stage_squash_r <= flush_i | fail_v_o | fault_sent_o;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (fetch_v_i)
      stage_pc_r <= fetch_pc_i;
  end

  assert property (@(posedge clk_i) disable iff (reset_i)
    fe_queue_v_o |-> fe_queue_ready_i);

  assert property (@(posedge clk_i) disable iff (reset_i)
    !(fail_v_o && fe_queue_v_o));

endmodule

`default_nettype wire

// File: src/fe_region_check.sv
`timescale 1ns/1ps
`default_nettype none

module fe_region_check
  import fe_pkg::*;
(
  input  logic   clk_i,
  input  logic   reset_i,

  input  logic   chk_v_i,
  input  vaddr_t chk_pc_i,

  output logic   access_fault_o,
  output logic   misaligned_o
);

  logic outside_n;
  logic misaligned_n;

  assign outside_n    = (chk_pc_i < exec_base) || (chk_pc_i >= exec_limit);
  assign misaligned_n = |chk_pc_i[1:0];

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      access_fault_o <= 1'b0;
      misaligned_o   <= 1'b0;
    end
    else
    begin
      // Misalignment wins over the region fault
      access_fault_o <= chk_v_i & outside_n & ~misaligned_n;
      misaligned_o   <= chk_v_i & misaligned_n;
    end
  end

endmodule

`default_nettype wire

// File: src/fe_top.sv
`timescale 1ns/1ps
`default_nettype none

module fe_top
  import fe_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,

  input  logic       fe_cmd_v_i,
  input  fe_cmd_op_e fe_cmd_op_i,
  input  vaddr_t     fe_cmd_pc_i,
  output logic       fe_cmd_yumi_o,

  input  logic       imem_w_v_i,
  input  imem_addr_t imem_w_addr_i,
  input  instr_t     imem_w_data_i,

  output logic       fe_queue_v_o,
  output fe_msg_e    fe_queue_msg_o,
  output vaddr_t     fe_queue_pc_o,
  output instr_t     fe_queue_instr_o,
  input  logic       fe_queue_ready_i
);

  logic   fetch_v;
  vaddr_t fetch_pc;
  logic   flush;
  instr_t rd_instr;
  logic   access_fault;
  logic   misaligned;
  logic   fail_v;
  vaddr_t fail_pc;
  logic   fault_sent;
  logic   resume_ready;

  fe_pc_gen pc_gen (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .fe_cmd_v_i     (fe_cmd_v_i),
    .fe_cmd_op_i    (fe_cmd_op_i),
    .fe_cmd_pc_i    (fe_cmd_pc_i),
    .fe_cmd_yumi_o  (fe_cmd_yumi_o),
    .fail_v_i       (fail_v),
    .fail_pc_i      (fail_pc),
    .fault_sent_i   (fault_sent),
    .resume_ready_i (resume_ready),
    .fetch_v_o      (fetch_v),
    .fetch_pc_o     (fetch_pc),
    .flush_o        (flush)
  );

  // Both lookups run in parallel on the issued PC
  fe_imem imem (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .imem_w_v_i    (imem_w_v_i),
    .imem_w_addr_i (imem_w_addr_i),
    .imem_w_data_i (imem_w_data_i),
    .rd_v_i        (fetch_v),
    .rd_pc_i       (fetch_pc),
    .rd_instr_o    (rd_instr)
  );

  fe_region_check region_check (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .chk_v_i        (fetch_v),
    .chk_pc_i       (fetch_pc),
    .access_fault_o (access_fault),
    .misaligned_o   (misaligned)
  );

  fe_queue_former queue_former (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .fetch_v_i        (fetch_v),
    .fetch_pc_i       (fetch_pc),
    .flush_i          (flush),
    .rd_instr_i       (rd_instr),
    .access_fault_i   (access_fault),
    .misaligned_i     (misaligned),
    .fe_queue_ready_i (fe_queue_ready_i),
    .fe_queue_v_o     (fe_queue_v_o),
    .fe_queue_msg_o   (fe_queue_msg_o),
    .fe_queue_pc_o    (fe_queue_pc_o),
    .fe_queue_instr_o (fe_queue_instr_o),
    .fail_v_o         (fail_v),
    .fail_pc_o        (fail_pc),
    .fault_sent_o     (fault_sent),
    .resume_ready_o   (resume_ready)
  );

endmodule

`default_nettype wire
